/* design/bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// Channel and address widths
`define BRIDGE_DWORD_W 64
`define BRIDGE_BE_W    8
`define BRIDGE_PADDR_W 40

// Next-PC register in the core's config block
`define BRIDGE_CFG_NPC_ADDR   40'h00_0020_0010

// Hart resumes here on debug entry
`define BRIDGE_DEBUGROM_ADDR  64'h0000_0000_0010_0800

// CLINT debug-interrupt register
`define BRIDGE_CLINT_DBG_ADDR 40'h00_0030_c000

// Hart-side window of the debug module, aligned to its own size
`define BRIDGE_DM_BASE   40'h00_0040_0000
`define BRIDGE_DM_WIN_W  20
`define BRIDGE_DM_OFS_W  17  // Dword offset inside the window

// Dword offsets in the window
`define BRIDGE_DM_DATA0_OFS  17'h00070
`define BRIDGE_DM_HALTED_OFS 17'h00020

`endif

/* design/mem_net_pkg.sv */
`default_nettype none
`include "bridge_defs.svh"

package mem_net_pkg;

  // Uncached message kinds
  typedef enum logic [1:0]
  {
    uc_rd      = 2'd0,
    uc_wr      = 2'd1,
    uc_resp_rd = 2'd2,
    uc_resp_wr = 2'd3
  } mem_msg_e;

  typedef enum logic [1:0]
  {
    size_1 = 2'd0,
    size_2 = 2'd1,
    size_4 = 2'd2,
    size_8 = 2'd3
  } mem_size_e;

  // Header and one dword of data, last is implied
  typedef struct packed
  {
    mem_msg_e                    msg_type;
    mem_size_e                   size;
    logic [`BRIDGE_PADDR_W-1:0]  addr;
    logic [1:0]                  src_id;
    logic [`BRIDGE_DWORD_W-1:0]  data;  // Lane aligned to addr
  } mem_fwd_t;

  typedef struct packed
  {
    mem_msg_e                    msg_type;
    mem_size_e                   size;
    logic [`BRIDGE_PADDR_W-1:0]  addr;
    logic [1:0]                  src_id;
    logic [`BRIDGE_DWORD_W-1:0]  data;
  } mem_rev_t;

endpackage

`default_nettype wire

/* design/dbg_pkg.sv */
`default_nettype none
`include "bridge_defs.svh"

package dbg_pkg;

  typedef enum logic [1:0]
  {
    dmi_nop   = 2'd0,
    dmi_read  = 2'd1,
    dmi_write = 2'd2
  } dmi_op_e;

  typedef struct packed
  {
    logic [6:0]   addr;
    dmi_op_e      op;
    logic [31:0]  data;
  } dmi_req_t;

  // resp is 0 for ok, 2 for failed
  typedef struct packed
  {
    logic [31:0]  data;
    logic [1:0]   resp;
  } dmi_resp_t;

  localparam logic [1:0] dmi_resp_ok = 2'd0;

  typedef struct packed
  {
    logic                        we;
    logic [`BRIDGE_PADDR_W-1:0]  addr;
    logic [`BRIDGE_DWORD_W-1:0]  wdata;
    logic [`BRIDGE_BE_W-1:0]     be;
  } sba_req_t;

  localparam logic [6:0] DMI_DATA0      = 7'h04;
  localparam logic [6:0] DMI_DMCONTROL  = 7'h10;
  localparam logic [6:0] DMI_DMSTATUS   = 7'h11;
  localparam logic [6:0] DMI_SBCS       = 7'h38;
  localparam logic [6:0] DMI_SBADDRESS0 = 7'h39;
  localparam logic [6:0] DMI_SBDATA0    = 7'h3c;

  // Only the fields this DM implements, the rest is zero
  typedef struct packed
  {
    logic         haltreq;
    logic [29:0]  zero;
    logic         dmactive;
  } dmcontrol_t;

  typedef struct packed
  {
    logic [19:0]  zero_hi;
    logic         allrunning;
    logic         anyrunning;
    logic         allhalted;
    logic         anyhalted;
    logic         authenticated;
    logic [2:0]   zero_lo;
    logic [3:0]   version;
  } dmstatus_t;

  typedef struct packed
  {
    logic [2:0]  sbversion;
    logic [5:0]  zero;
    logic        sbbusyerror;
    logic        sbbusy;
    logic        sbreadonaddr;
    logic [2:0]  sbaccess;
    logic        sbautoincrement;
    logic        sbreadondata;
    logic [2:0]  sberror;
    logic [6:0]  sbasize;
    logic [4:0]  sbaccess_sup;  // 128/64/32/16/8 bit support
  } sbcs_t;

endpackage

`default_nettype wire

/* design/dbg_reg_endpoint.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bridge_defs.svh"

module dbg_reg_endpoint
  (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire mem_net_pkg::mem_fwd_t   mem_fwd_i,
    input  wire                          mem_fwd_v_i,
    output logic                         mem_fwd_ready_and_o,
    output mem_net_pkg::mem_rev_t        mem_rev_o,
    output logic                         mem_rev_v_o,
    input  wire                          mem_rev_ready_and_i,
    output logic                         reg_r_v_o,
    output logic                         reg_w_v_o,
    output logic [`BRIDGE_DM_OFS_W-1:0]  reg_addr_o,
    output logic [`BRIDGE_BE_W-1:0]      reg_be_o,
    output logic [`BRIDGE_DWORD_W-1:0]   reg_wdata_o,
    input  wire [`BRIDGE_DWORD_W-1:0]    reg_rdata_i
  );
  import mem_net_pkg::*;

  localparam logic [`BRIDGE_PADDR_W-1:0] dm_base_lp = `BRIDGE_DM_BASE;

  logic                        fwd_fire;
  logic                        in_win;
  logic [`BRIDGE_DWORD_W-1:0]  lane_mask;
  mem_rev_t                    rev_r;
  logic                        rev_v_r;

  assign fwd_fire = mem_fwd_v_i & mem_fwd_ready_and_o;
  assign in_win = (mem_fwd_i.addr[`BRIDGE_PADDR_W-1:`BRIDGE_DM_WIN_W]
                   == dm_base_lp[`BRIDGE_PADDR_W-1:`BRIDGE_DM_WIN_W]);

  assign mem_fwd_ready_and_o = ~rev_v_r;  // Stall while the response waits
  assign reg_r_v_o = fwd_fire & in_win & (mem_fwd_i.msg_type == uc_rd);
  assign reg_w_v_o = fwd_fire & in_win & (mem_fwd_i.msg_type == uc_wr);
  assign reg_addr_o = mem_fwd_i.addr[`BRIDGE_DM_WIN_W-1:3];
  assign reg_wdata_o = mem_fwd_i.data;

  always_comb
  begin
    case (mem_fwd_i.size)
      size_1:  reg_be_o = 8'h01 << mem_fwd_i.addr[2:0];
      size_2:  reg_be_o = 8'h03 << mem_fwd_i.addr[2:0];
      size_4:  reg_be_o = 8'h0f << mem_fwd_i.addr[2:0];
      default: reg_be_o = 8'hff;
    endcase
    for (int i = 0; i < `BRIDGE_BE_W; i++)
    begin
      lane_mask[8*i +: 8] = {8{reg_be_o[i]}};
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rev_v_r <= 1'b0;
    else if (fwd_fire)
      rev_v_r <= 1'b1;
    else if (mem_rev_ready_and_i)
      rev_v_r <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (fwd_fire)
    begin
      rev_r.msg_type <= (mem_fwd_i.msg_type == uc_rd) ? uc_resp_rd : uc_resp_wr;
      rev_r.size <= mem_fwd_i.size;
      rev_r.addr <= mem_fwd_i.addr;
      rev_r.src_id <= mem_fwd_i.src_id;
      rev_r.data <= reg_r_v_o ? (reg_rdata_i & lane_mask) : '0;  // Zero outside window
    end
  end

  assign mem_rev_o = rev_r;
  assign mem_rev_v_o = rev_v_r;

endmodule

`default_nettype wire

/* design/dbg_module.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bridge_defs.svh"

module dbg_module
  (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire dbg_pkg::dmi_req_t       dmi_req_i,
    input  wire                          dmi_req_v_i,
    output logic                         dmi_req_ready_and_o,
    output dbg_pkg::dmi_resp_t           dmi_resp_o,
    output logic                         dmi_resp_v_o,
    input  wire                          dmi_resp_ready_and_i,
    input  wire                          reg_r_v_i,
    input  wire                          reg_w_v_i,
    input  wire [`BRIDGE_DM_OFS_W-1:0]   reg_addr_i,
    input  wire [`BRIDGE_BE_W-1:0]       reg_be_i,
    input  wire [`BRIDGE_DWORD_W-1:0]    reg_wdata_i,
    output logic [`BRIDGE_DWORD_W-1:0]   reg_rdata_o,
    output logic                         debug_req_o,
    output dbg_pkg::sba_req_t            sba_req_o,
    output logic                         sba_v_o,
    input  wire                          sba_gnt_i,
    input  wire                          sba_rvalid_i,
    input  wire [`BRIDGE_DWORD_W-1:0]    sba_rdata_i
  );
  import dbg_pkg::*;

  logic                        haltreq_r;
  logic                        allhalted_r;
  logic                        sbbusy_r;
  logic [2:0]                  sbaccess_r;
  logic                        resp_v_r;
  logic                        sba_v_r;
  logic [31:0]                 data0_r;
  logic [31:0]                 sbaddr_r;
  logic [31:0]                 sbdata_r;
  dmi_resp_t                   resp_r;
  sba_req_t                    sba_r;
  logic                        dmi_fire;
  logic                        dmi_rd;
  logic                        dmi_wr;
  logic                        sb_launch;
  logic [31:0]                 dmi_rdata;
  dmcontrol_t                  dmcontrol_rd;
  dmcontrol_t                  dmcontrol_wr;
  dmstatus_t                   dmstatus_rd;
  sbcs_t                       sbcs_rd;
  sbcs_t                       sbcs_wr;
  logic [2:0]                  sb_ofs;
  logic [`BRIDGE_BE_W-1:0]     sb_be;
  logic [`BRIDGE_DWORD_W-1:0]  sb_rshift;
  logic [31:0]                 sb_rdata;
  logic                        hart_data0;
  logic                        hart_halted;

  // SBDATA0 stalls while a bus access is in flight
  assign dmi_req_ready_and_o = ~resp_v_r & ~(sbbusy_r & (dmi_req_i.addr == DMI_SBDATA0));
  assign dmi_fire = dmi_req_v_i & dmi_req_ready_and_o;
  assign dmi_rd = dmi_fire & (dmi_req_i.op == dmi_read);
  assign dmi_wr = dmi_fire & (dmi_req_i.op == dmi_write);
  assign sb_launch = (dmi_rd | dmi_wr) & (dmi_req_i.addr == DMI_SBDATA0);
  assign dmcontrol_wr = dmcontrol_t'(dmi_req_i.data);
  assign sbcs_wr = sbcs_t'(dmi_req_i.data);

  always_comb
  begin
    dmcontrol_rd = '0;
    dmcontrol_rd.haltreq = haltreq_r;
    dmcontrol_rd.dmactive = 1'b1;
    dmstatus_rd = '0;
    dmstatus_rd.version = 4'd2;  // Spec 0.13
    dmstatus_rd.authenticated = 1'b1;
    dmstatus_rd.allhalted = allhalted_r;
    dmstatus_rd.anyhalted = allhalted_r;
    dmstatus_rd.allrunning = ~allhalted_r;
    dmstatus_rd.anyrunning = ~allhalted_r;
    sbcs_rd = '0;
    sbcs_rd.sbversion = 3'd1;
    sbcs_rd.sbbusy = sbbusy_r;
    sbcs_rd.sbaccess = sbaccess_r;
    sbcs_rd.sbasize = 7'd32;
    sbcs_rd.sbaccess_sup = 5'b00111;  // 8, 16 and 32 bit
    case (dmi_req_i.addr)
      DMI_DATA0:      dmi_rdata = data0_r;
      DMI_DMCONTROL:  dmi_rdata = dmcontrol_rd;
      DMI_DMSTATUS:   dmi_rdata = dmstatus_rd;
      DMI_SBCS:       dmi_rdata = sbcs_rd;
      DMI_SBADDRESS0: dmi_rdata = sbaddr_r;
      DMI_SBDATA0:    dmi_rdata = sbdata_r;
      default:        dmi_rdata = '0;
    endcase
  end

  // Hart side
  assign hart_data0 = (reg_addr_i == `BRIDGE_DM_DATA0_OFS);
  assign hart_halted = (reg_addr_i == `BRIDGE_DM_HALTED_OFS);

  always_comb
  begin
    reg_rdata_o = '0;
    if (reg_r_v_i && hart_data0)
      reg_rdata_o = `BRIDGE_DWORD_W'(data0_r);
    else if (reg_r_v_i && hart_halted)
      reg_rdata_o = `BRIDGE_DWORD_W'(allhalted_r);
  end

  // System bus lanes follow the low address bits
  assign sb_ofs = sbaddr_r[2:0];
  assign sb_rshift = sba_rdata_i >> {sba_r.addr[2:0], 3'b000};

  always_comb
  begin
    case (sbaccess_r)
      3'd0:    sb_be = 8'h01 << sb_ofs;
      3'd1:    sb_be = 8'h03 << sb_ofs;
      default: sb_be = 8'h0f << sb_ofs;
    endcase
    case (sbaccess_r)
      3'd0:    sb_rdata = {24'b0, sb_rshift[7:0]};
      3'd1:    sb_rdata = {16'b0, sb_rshift[15:0]};
      default: sb_rdata = sb_rshift[31:0];
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      haltreq_r <= 1'b0;
      allhalted_r <= 1'b0;
      sbbusy_r <= 1'b0;
      sbaccess_r <= 3'd2;
      sba_v_r <= 1'b0;
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (dmi_wr && dmi_req_i.addr == DMI_DMCONTROL)
      begin
        haltreq_r <= dmcontrol_wr.haltreq;
        if (!dmcontrol_wr.haltreq)
          allhalted_r <= 1'b0;
      end
      if (reg_w_v_i && hart_halted)
        allhalted_r <= 1'b1;  // Doorbell from the debug ROM
      if (dmi_wr && dmi_req_i.addr == DMI_SBCS)
        sbaccess_r <= sbcs_wr.sbaccess;
      if (sb_launch)
      begin
        sba_v_r <= 1'b1;
        sbbusy_r <= 1'b1;
      end
      else
      begin
        if (sba_gnt_i)
          sba_v_r <= 1'b0;
        if (sba_rvalid_i)
          sbbusy_r <= 1'b0;
      end
      if (dmi_fire)
        resp_v_r <= 1'b1;
      else if (dmi_resp_ready_and_i)
        resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (dmi_fire)
    begin
      resp_r.data <= dmi_rd ? dmi_rdata : '0;
      resp_r.resp <= dmi_resp_ok;
    end
    if (dmi_wr && dmi_req_i.addr == DMI_DATA0)
      data0_r <= dmi_req_i.data;
    if (reg_w_v_i && hart_data0)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (reg_be_i[i])
          data0_r[8*i +: 8] <= reg_wdata_i[8*i +: 8];  // Hart wins the conflict
      end
    end
    if (dmi_wr && dmi_req_i.addr == DMI_SBADDRESS0)
      sbaddr_r <= dmi_req_i.data;
    if (dmi_wr && dmi_req_i.addr == DMI_SBDATA0)
      sbdata_r <= dmi_req_i.data;
    else if (sba_rvalid_i && !sba_r.we)
      sbdata_r <= sb_rdata;
    if (sb_launch)
    begin
      sba_r.we <= dmi_wr;
      sba_r.addr <= `BRIDGE_PADDR_W'(sbaddr_r);
      sba_r.wdata <= `BRIDGE_DWORD_W'(dmi_req_i.data) << {sb_ofs, 3'b000};
      sba_r.be <= sb_be;
    end
  end

  assign dmi_resp_o = resp_r;
  assign dmi_resp_v_o = resp_v_r;
  assign debug_req_o = haltreq_r;
  assign sba_req_o = sba_r;
  assign sba_v_o = sba_v_r;

endmodule

`default_nettype wire

/* design/dbg_fwd_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bridge_defs.svh"

module dbg_fwd_sequencer
  (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire                          debug_req_i,
    input  wire dbg_pkg::sba_req_t       sba_req_i,
    input  wire                          sba_v_i,
    output logic                         sba_gnt_o,
    output logic                         sba_rvalid_o,
    output logic [`BRIDGE_DWORD_W-1:0]   sba_rdata_o,
    output mem_net_pkg::mem_fwd_t        mem_fwd_o,
    output logic                         mem_fwd_v_o,
    input  wire                          mem_fwd_ready_and_i,
    input  wire mem_net_pkg::mem_rev_t   mem_rev_i,
    input  wire                          mem_rev_v_i,
    output logic                         mem_rev_ready_and_o
  );
  import mem_net_pkg::*;
  import dbg_pkg::*;

  localparam logic [1:0] src_id_lp = 2'b10;

  typedef enum logic [2:0]
  {
    e_ready,
    e_send_npc,
    e_send_hireq,
    e_send_loreq,
    e_lower_req,
    e_send_sba
  } state_e;

  state_e  state_r;
  state_e  state_n;
  logic    outstanding_r;
  logic    fwd_fire;
  logic    rev_fire;
  logic    sending;

  assign mem_rev_ready_and_o = 1'b1;
  assign fwd_fire = mem_fwd_v_o & mem_fwd_ready_and_i;
  assign rev_fire = mem_rev_v_i & mem_rev_ready_and_o;
  assign sending = (state_r == e_send_npc) | (state_r == e_send_hireq)
                 | (state_r == e_send_loreq) | (state_r == e_send_sba);

  // One message in flight at a time
  assign mem_fwd_v_o = sending & ~outstanding_r;

  assign sba_gnt_o = fwd_fire & (state_r == e_send_sba);
  assign sba_rvalid_o = rev_fire & (state_r == e_send_sba);
  assign sba_rdata_o = mem_rev_i.data;

  always_comb
  begin
    mem_fwd_o = '0;
    mem_fwd_o.msg_type = uc_wr;
    mem_fwd_o.size = size_8;
    mem_fwd_o.src_id = src_id_lp;
    state_n = state_r;
    case (state_r)
      e_ready:
      begin
        if (debug_req_i)
          state_n = e_send_npc;  // Halt wins over SBA
        else if (sba_v_i)
          state_n = e_send_sba;
      end
      e_send_npc:
      begin
        mem_fwd_o.addr = `BRIDGE_CFG_NPC_ADDR;
        mem_fwd_o.data = `BRIDGE_DEBUGROM_ADDR;
        if (rev_fire)
          state_n = e_send_hireq;
      end
      e_send_hireq:
      begin
        mem_fwd_o.addr = `BRIDGE_CLINT_DBG_ADDR;
        mem_fwd_o.data = `BRIDGE_DWORD_W'(1);
        if (rev_fire)
          state_n = e_send_loreq;
      end
      e_send_loreq:
      begin
        mem_fwd_o.addr = `BRIDGE_CLINT_DBG_ADDR;  // Data stays zero
        if (rev_fire)
          state_n = e_lower_req;
      end
      e_lower_req:
      begin
        if (!debug_req_i)
          state_n = e_ready;
      end
      e_send_sba:
      begin
        mem_fwd_o.msg_type = sba_req_i.we ? uc_wr : uc_rd;
        mem_fwd_o.addr = sba_req_i.addr;
        mem_fwd_o.data = sba_req_i.we ? sba_req_i.wdata : '0;
        case (sba_req_i.be)
          8'h01, 8'h02, 8'h04, 8'h08,
          8'h10, 8'h20, 8'h40, 8'h80: mem_fwd_o.size = size_1;
          8'h03, 8'h0c, 8'h30, 8'hc0: mem_fwd_o.size = size_2;
          8'h0f, 8'hf0:               mem_fwd_o.size = size_4;
          default:                    mem_fwd_o.size = size_8;
        endcase
        if (rev_fire)
          state_n = e_ready;
      end
      default:
      begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_ready;
      outstanding_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (fwd_fire)
        outstanding_r <= 1'b1;
      else if (rev_fire)
        outstanding_r <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/dbg_bridge.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bridge_defs.svh"

module dbg_bridge
  (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire dbg_pkg::dmi_req_t       dmi_req_i,
    input  wire                          dmi_req_v_i,
    output logic                         dmi_req_ready_and_o,
    output dbg_pkg::dmi_resp_t           dmi_resp_o,
    output logic                         dmi_resp_v_o,
    input  wire                          dmi_resp_ready_and_i,
    output mem_net_pkg::mem_fwd_t        mem_fwd_o,
    output logic                         mem_fwd_v_o,
    input  wire                          mem_fwd_ready_and_i,
    input  wire mem_net_pkg::mem_rev_t   mem_rev_i,
    input  wire                          mem_rev_v_i,
    output logic                         mem_rev_ready_and_o,
    input  wire mem_net_pkg::mem_fwd_t   mem_fwd_i,
    input  wire                          mem_fwd_v_i,
    output logic                         mem_fwd_ready_and_o,
    output mem_net_pkg::mem_rev_t        mem_rev_o,
    output logic                         mem_rev_v_o,
    input  wire                          mem_rev_ready_and_i
  );
  import dbg_pkg::*;

  logic                        reg_r_v;
  logic                        reg_w_v;
  logic [`BRIDGE_DM_OFS_W-1:0] reg_addr;
  logic [`BRIDGE_BE_W-1:0]     reg_be;
  logic [`BRIDGE_DWORD_W-1:0]  reg_wdata;
  logic [`BRIDGE_DWORD_W-1:0]  reg_rdata;
  logic                        debug_req;
  sba_req_t                    sba_req;
  logic                        sba_v;
  logic                        sba_gnt;
  logic                        sba_rvalid;
  logic [`BRIDGE_DWORD_W-1:0]  sba_rdata;

  // Hart-side view of the debug module
  dbg_reg_endpoint endpoint0
    (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .mem_fwd_i           (mem_fwd_i),
      .mem_fwd_v_i         (mem_fwd_v_i),
      .mem_fwd_ready_and_o (mem_fwd_ready_and_o),
      .mem_rev_o           (mem_rev_o),
      .mem_rev_v_o         (mem_rev_v_o),
      .mem_rev_ready_and_i (mem_rev_ready_and_i),
      .reg_r_v_o           (reg_r_v),
      .reg_w_v_o           (reg_w_v),
      .reg_addr_o          (reg_addr),
      .reg_be_o            (reg_be),
      .reg_wdata_o         (reg_wdata),
      .reg_rdata_i         (reg_rdata)
    );

  dbg_module dm0
    (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .dmi_req_i            (dmi_req_i),
      .dmi_req_v_i          (dmi_req_v_i),
      .dmi_req_ready_and_o  (dmi_req_ready_and_o),
      .dmi_resp_o           (dmi_resp_o),
      .dmi_resp_v_o         (dmi_resp_v_o),
      .dmi_resp_ready_and_i (dmi_resp_ready_and_i),
      .reg_r_v_i            (reg_r_v),
      .reg_w_v_i            (reg_w_v),
      .reg_addr_i           (reg_addr),
      .reg_be_i             (reg_be),
      .reg_wdata_i          (reg_wdata),
      .reg_rdata_o          (reg_rdata),
      .debug_req_o          (debug_req),
      .sba_req_o            (sba_req),
      .sba_v_o              (sba_v),
      .sba_gnt_i            (sba_gnt),
      .sba_rvalid_i         (sba_rvalid),
      .sba_rdata_i          (sba_rdata)
    );

  // Drives the outgoing forward channel
  dbg_fwd_sequencer seq0
    (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .debug_req_i         (debug_req),
      .sba_req_i           (sba_req),
      .sba_v_i             (sba_v),
      .sba_gnt_o           (sba_gnt),
      .sba_rvalid_o        (sba_rvalid),
      .sba_rdata_o         (sba_rdata),
      .mem_fwd_o           (mem_fwd_o),
      .mem_fwd_v_o         (mem_fwd_v_o),
      .mem_fwd_ready_and_i (mem_fwd_ready_and_i),
      .mem_rev_i           (mem_rev_i),
      .mem_rev_v_i         (mem_rev_v_i),
      .mem_rev_ready_and_o (mem_rev_ready_and_o)
    );

endmodule

`default_nettype wire

/* bench/mem_responder.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bridge_defs.svh"

module mem_responder
  (
    input  wire                          clk_i,
    input  wire                          reset_i,
    input  wire mem_net_pkg::mem_fwd_t   mem_fwd_i,
    input  wire                          mem_fwd_v_i,
    output logic                         mem_fwd_ready_and_o,
    output mem_net_pkg::mem_rev_t        mem_rev_o,
    output logic                         mem_rev_v_o,
    input  wire                          mem_rev_ready_and_i
  );
  import mem_net_pkg::*;

  mem_fwd_t  log_q[$];  // Every message taken, in arrival order

  mem_fwd_t  held;
  logic      fwd_fire;
  logic      rev_fire;
  logic      pending;
  int        delay;

  // Load data depends on the whole address
  function automatic logic [`BRIDGE_DWORD_W-1:0] read_fill
    (
      input logic [`BRIDGE_PADDR_W-1:0] addr
    );
    read_fill = 64'h0123_4567_89ab_cdef ^ {24'h0, addr};
  endfunction

  initial
  begin
    mem_fwd_ready_and_o = 1'b0;
    mem_rev_v_o = 1'b0;
    mem_rev_o = '0;
    held = '0;
    pending = 1'b0;
    delay = 0;
    forever
    begin
      // Handshakes are settled by the falling edge
      @(negedge clk_i);
      fwd_fire = mem_fwd_v_i & mem_fwd_ready_and_o;
      rev_fire = mem_rev_v_o & mem_rev_ready_and_i;
      if (fwd_fire)
        held = mem_fwd_i;
      @(posedge clk_i);
      #1;
      if (rev_fire)
        mem_rev_v_o = 1'b0;
      if (fwd_fire)
      begin
        log_q.push_back(held);
        pending = 1'b1;
        delay = $urandom_range(0, 5);
      end
      else if (pending && delay > 0)
        delay = delay - 1;
      if (pending && delay == 0)
      begin
        mem_rev_o.msg_type = (held.msg_type == uc_rd) ? uc_resp_rd : uc_resp_wr;
        mem_rev_o.size = held.size;
        mem_rev_o.addr = held.addr;
        mem_rev_o.src_id = held.src_id;
        mem_rev_o.data = (held.msg_type == uc_rd) ? read_fill(held.addr) : '0;
        mem_rev_v_o = 1'b1;
        pending = 1'b0;
      end
      // One message at a time, with random stalls
      mem_fwd_ready_and_o = !reset_i && !pending && !mem_rev_v_o
                            && ($urandom_range(0, 3) != 0);
    end
  end

endmodule

`default_nettype wire

/* bench/dbg_bridge_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "bridge_defs.svh"

module dbg_bridge_tb;
  import mem_net_pkg::*;
  import dbg_pkg::*;

  typedef enum logic [2:0]
  {
    k_dmi_wr,
    k_dmi_rd,
    k_hart_st,
    k_hart_ld,
    k_exp_fwd,
    k_quiet
  } step_kind_e;

  typedef struct packed
  {
    logic [8*16-1:0]             name;
    step_kind_e                  kind;
    mem_msg_e                    msg;
    logic [`BRIDGE_PADDR_W-1:0]  addr;
    logic [`BRIDGE_DWORD_W-1:0]  data;
    mem_size_e                   size;
    logic [`BRIDGE_DWORD_W-1:0]  expected;
  } step_t;

  logic       clk_i;
  logic       reset_i;
  dmi_req_t   dmi_req;
  logic       dmi_req_v;
  logic       dmi_req_ready;
  dmi_resp_t  dmi_resp;
  logic       dmi_resp_v;
  logic       dmi_resp_ready;
  mem_fwd_t   net_fwd;
  logic       net_fwd_v;
  logic       net_fwd_ready;
  mem_rev_t   net_rev;
  logic       net_rev_v;
  logic       net_rev_ready;
  mem_fwd_t   hart_fwd;
  logic       hart_fwd_v;
  logic       hart_fwd_ready;
  mem_rev_t   hart_rev;
  logic       hart_rev_v;
  logic       hart_rev_ready;
  step_t      steps[$];
  int         watchdog_cycles;
  int         seed_val;

  dbg_bridge dut0
    (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .dmi_req_i            (dmi_req),
      .dmi_req_v_i          (dmi_req_v),
      .dmi_req_ready_and_o  (dmi_req_ready),
      .dmi_resp_o           (dmi_resp),
      .dmi_resp_v_o         (dmi_resp_v),
      .dmi_resp_ready_and_i (dmi_resp_ready),
      .mem_fwd_o            (net_fwd),
      .mem_fwd_v_o          (net_fwd_v),
      .mem_fwd_ready_and_i  (net_fwd_ready),
      .mem_rev_i            (net_rev),
      .mem_rev_v_i          (net_rev_v),
      .mem_rev_ready_and_o  (net_rev_ready),
      .mem_fwd_i            (hart_fwd),
      .mem_fwd_v_i          (hart_fwd_v),
      .mem_fwd_ready_and_o  (hart_fwd_ready),
      .mem_rev_o            (hart_rev),
      .mem_rev_v_o          (hart_rev_v),
      .mem_rev_ready_and_i  (hart_rev_ready)
    );

  mem_responder resp0
    (
      .clk_i               (clk_i),
      .reset_i             (reset_i),
      .mem_fwd_i           (net_fwd),
      .mem_fwd_v_i         (net_fwd_v),
      .mem_fwd_ready_and_o (net_fwd_ready),
      .mem_rev_o           (net_rev),
      .mem_rev_v_o         (net_rev_v),
      .mem_rev_ready_and_i (net_rev_ready)
    );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  function automatic logic [`BRIDGE_PADDR_W-1:0] dm_addr
    (
      input logic [`BRIDGE_DM_OFS_W-1:0] ofs,
      input logic [2:0]                  byte_ofs
    );
    dm_addr = `BRIDGE_DM_BASE | {20'h0, ofs, 3'b000} | {37'h0, byte_ofs};
  endfunction

  function automatic void add_step
    (
      input logic [8*16-1:0]             name,
      input step_kind_e                  kind,
      input mem_msg_e                    msg,
      input logic [`BRIDGE_PADDR_W-1:0]  addr,
      input logic [`BRIDGE_DWORD_W-1:0]  data,
      input mem_size_e                   size,
      input logic [`BRIDGE_DWORD_W-1:0]  expected
    );
    step_t s;
    s = '{name: name, kind: kind, msg: msg, addr: addr, data: data, size: size,
          expected: expected};
    steps.push_back(s);
  endfunction

  function automatic void build_table();
    add_step("data0_wr", k_dmi_wr, uc_rd, DMI_DATA0, 64'ha5a5_1234, size_8, 64'h0);
    add_step("data0_rd", k_dmi_rd, uc_rd, DMI_DATA0, 64'h0, size_8, 64'ha5a5_1234);
    add_step("unmapped_rd", k_dmi_rd, uc_rd, 40'h20, 64'h0, size_8, 64'h0);
    add_step("haltreq_set", k_dmi_wr, uc_rd, DMI_DMCONTROL, 64'h8000_0001, size_8, 64'h0);
    add_step("npc_store", k_exp_fwd, uc_wr, `BRIDGE_CFG_NPC_ADDR, 64'h0, size_8,
             `BRIDGE_DEBUGROM_ADDR);
    add_step("dbg_irq_hi", k_exp_fwd, uc_wr, `BRIDGE_CLINT_DBG_ADDR, 64'h0, size_8, 64'h1);
    add_step("dbg_irq_lo", k_exp_fwd, uc_wr, `BRIDGE_CLINT_DBG_ADDR, 64'h0, size_8, 64'h0);
    add_step("halt_quiet", k_quiet, uc_rd, 40'h0, 64'h0, size_8, 64'h0);
    add_step("halted_bell", k_hart_st, uc_wr, dm_addr(`BRIDGE_DM_HALTED_OFS, 3'd0),
             64'h1, size_8, 64'h0);
    add_step("status_halted", k_dmi_rd, uc_rd, DMI_DMSTATUS, 64'h0, size_8, 64'h382);
    add_step("haltreq_clr", k_dmi_wr, uc_rd, DMI_DMCONTROL, 64'h1, size_8, 64'h0);
    add_step("status_running", k_dmi_rd, uc_rd, DMI_DMSTATUS, 64'h0, size_8, 64'hc82);
    add_step("hart_data0_st", k_hart_st, uc_wr, dm_addr(`BRIDGE_DM_DATA0_OFS, 3'd0),
             64'hcafe_f00d, size_4, 64'h0);
    add_step("data0_from_hart", k_dmi_rd, uc_rd, DMI_DATA0, 64'h0, size_8, 64'hcafe_f00d);
    add_step("data0_wr2", k_dmi_wr, uc_rd, DMI_DATA0, 64'h1234_5678, size_8, 64'h0);
    add_step("hart_ld_half", k_hart_ld, uc_rd, dm_addr(`BRIDGE_DM_DATA0_OFS, 3'd2),
             64'h0, size_2, 64'h1234_0000);
    add_step("hart_ld_dword", k_hart_ld, uc_rd, dm_addr(`BRIDGE_DM_DATA0_OFS, 3'd0),
             64'h0, size_8, 64'h1234_5678);
    add_step("sbcs_16bit", k_dmi_wr, uc_rd, DMI_SBCS, 64'h0002_0000, size_8, 64'h0);
    add_step("sbaddr_wr", k_dmi_wr, uc_rd, DMI_SBADDRESS0, 64'h8000_1002, size_8, 64'h0);
    add_step("sbdata_wr", k_dmi_wr, uc_rd, DMI_SBDATA0, 64'h0000_beef, size_8, 64'h0);
    add_step("sba_store", k_exp_fwd, uc_wr, 40'h00_8000_1002, 64'h0, size_2,
             64'h0000_0000_beef_0000);
    add_step("sbdata_rd", k_dmi_rd, uc_rd, DMI_SBDATA0, 64'h0, size_8, 64'h0000_beef);
    add_step("sba_load", k_exp_fwd, uc_rd, 40'h00_8000_1002, 64'h0, size_2, 64'h0);
    // Halfword at byte 2 of the responder fill for this address
    add_step("sbdata_readback", k_dmi_rd, uc_rd, DMI_SBDATA0, 64'h0, size_8, 64'h09ab);
    add_step("sba_load2", k_exp_fwd, uc_rd, 40'h00_8000_1002, 64'h0, size_2, 64'h0);
  endfunction

  task automatic check_dmi_resp(input logic [8*16-1:0] name, input dmi_resp_t exp,
                                input dmi_resp_t act);
    if (act !== exp)
      abort_run($sformatf("MISMATCH %0s expected data %h resp %0d actual data %h resp %0d",
                          name, exp.data, exp.resp, act.data, act.resp));
  endtask

  task automatic check_fwd(input logic [8*16-1:0] name, input mem_fwd_t exp,
                           input mem_fwd_t act);
    if (act.msg_type !== exp.msg_type || act.size !== exp.size
        || act.addr !== exp.addr || act.data !== exp.data)
      abort_run($sformatf("MISMATCH %0s expected %0s/%0s %h %h actual %0s/%0s %h %h",
                          name, exp.msg_type.name(), exp.size.name(), exp.addr, exp.data,
                          act.msg_type.name(), act.size.name(), act.addr, act.data));
  endtask

  task automatic check_rev(input logic [8*16-1:0] name, input mem_rev_t exp,
                           input mem_rev_t act);
    if (act !== exp)
      abort_run($sformatf("MISMATCH %0s expected %h actual %h", name, exp, act));
  endtask

  // Called and returns one ns after a rising edge
  task automatic dmi_transfer(input dmi_req_t req, output dmi_resp_t resp);
    logic done;
    dmi_req = req;
    dmi_req_v = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk_i);
      done = dmi_req_ready;
      @(posedge clk_i);
      #1;
    end
    dmi_req_v = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      dmi_resp_ready = ($urandom_range(0, 2) != 0);  // Random stall
      @(negedge clk_i);
      done = dmi_resp_v & dmi_resp_ready;
      resp = dmi_resp;
      @(posedge clk_i);
      #1;
    end
    dmi_resp_ready = 1'b0;
  endtask

  task automatic hart_transfer(input mem_fwd_t fwd, output mem_rev_t rev);
    logic done;
    hart_fwd = fwd;
    hart_fwd_v = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      @(negedge clk_i);
      done = hart_fwd_ready;
      @(posedge clk_i);
      #1;
    end
    hart_fwd_v = 1'b0;
    done = 1'b0;
    while (!done)
    begin
      hart_rev_ready = ($urandom_range(0, 2) != 0);
      @(negedge clk_i);
      done = hart_rev_v & hart_rev_ready;
      rev = hart_rev;
      @(posedge clk_i);
      #1;
    end
    hart_rev_ready = 1'b0;
  endtask

  task automatic wait_forward(output mem_fwd_t msg);
    @(negedge clk_i);
    while (resp0.log_q.size() == 0)
      @(negedge clk_i);
    msg = resp0.log_q.pop_front();
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_step(input step_t s);
    dmi_req_t   req;
    dmi_resp_t  resp;
    dmi_resp_t  resp_exp;
    mem_fwd_t   fwd;
    mem_fwd_t   fwd_exp;
    mem_rev_t   rev;
    mem_rev_t   rev_exp;
    case (s.kind)
      k_dmi_wr, k_dmi_rd:
      begin
        req = '{addr: s.addr[6:0], op: (s.kind == k_dmi_wr) ? dmi_write : dmi_read,
                data: s.data[31:0]};
        dmi_transfer(req, resp);
        resp_exp = '{data: s.expected[31:0], resp: 2'b00};
        check_dmi_resp(s.name, resp_exp, resp);
      end
      k_hart_st, k_hart_ld:
      begin
        fwd = '{msg_type: (s.kind == k_hart_st) ? uc_wr : uc_rd, size: s.size,
                addr: s.addr, src_id: 2'd0, data: s.data};
        hart_transfer(fwd, rev);
        rev_exp = '{msg_type: (s.kind == k_hart_st) ? uc_resp_wr : uc_resp_rd,
                    size: s.size, addr: s.addr, src_id: 2'd0, data: s.expected};
        check_rev(s.name, rev_exp, rev);
      end
      k_exp_fwd:
      begin
        wait_forward(fwd);
        fwd_exp = '{msg_type: s.msg, size: s.size, addr: s.addr, src_id: 2'd0,
                    data: s.expected};
        check_fwd(s.name, fwd_exp, fwd);
      end
      default:
      begin
        repeat (20) @(negedge clk_i);
        if (resp0.log_q.size() != 0)
          abort_run("A forward message appeared while haltreq was still held");
        @(posedge clk_i);
        #1;
      end
    endcase
  endtask

  initial
  begin
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk_i);
    abort_run($sformatf("Timeout: the run hung, not done after %0d cycles",
                        watchdog_cycles));
  end

  initial
  begin
    seed_val = $urandom(32'h17110775);
    clk_i = 1'b0;
    reset_i = 1'b1;
    dmi_req = '0;
    dmi_req_v = 1'b0;
    dmi_resp_ready = 1'b0;
    hart_fwd = '0;
    hart_fwd_v = 1'b0;
    hart_rev_ready = 1'b0;
    build_table();
    watchdog_cycles = 300 * steps.size() + 8;
    repeat (8) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    foreach (steps[i])
      run_step(steps[i]);
    repeat (20) @(negedge clk_i);  // Let any stray message reach the log
    if (resp0.log_q.size() != 0)
      abort_run("Extra message on the outgoing forward channel");
    else
    begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+design
design/mem_net_pkg.sv
design/dbg_pkg.sv
design/dbg_reg_endpoint.sv
design/dbg_module.sv
design/dbg_fwd_sequencer.sv
design/dbg_bridge.sv
bench/mem_responder.sv
bench/dbg_bridge_tb.sv
